// File: bench/tb_mpf_lite_top.sv
// Random traffic testbench for mpf_lite_top with a memory model, tag tables and timeout

`timescale 1ns/1ps

module tb_mpf_lite_top
    import mpf_lite_pkg::*;
();

    // ========================================
    // Run length and limits
    // ========================================

    localparam int SEED           = 53904;
    localparam int DIRECTED_REQS  = 3;
    localparam int RANDOM_REQS    = 300;
    localparam int FLOOD_MAX      = 32;
    localparam int FAIR_REQS      = 40;
    localparam int TOTAL_REQS     = DIRECTED_REQS + RANDOM_REQS + 2 * FLOOD_MAX + 2 * FAIR_REQS;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_REQS + 200;
    localparam int TAGS           = 1 << TAG_BITS;

    logic                 clk;
    logic                 rst;
    logic                 c0_tx_valid;
    logic [ADDR_BITS-1:0] c0_tx_addr;
    logic [TAG_BITS-1:0]  c0_tx_tag;
    logic                 c1_tx_valid;
    logic [ADDR_BITS-1:0] c1_tx_addr;
    logic [TAG_BITS-1:0]  c1_tx_tag;
    logic [DATA_BITS-1:0] c1_tx_data;
    logic                 c0_tx_alm_full;
    logic                 c1_tx_alm_full;
    logic                 c0_rx_valid;
    logic [TAG_BITS-1:0]  c0_rx_tag;
    logic [DATA_BITS-1:0] c0_rx_data;
    logic                 c1_rx_valid;
    logic [TAG_BITS-1:0]  c1_rx_tag;

    // Reference memory, updated when a write is sent
    logic [DATA_BITS-1:0] model_mem [MEM_WORDS];

    // Outstanding tags per channel, with the address each one touches
    bit                   c0_pend    [TAGS];
    logic [DATA_BITS-1:0] c0_exp     [TAGS];
    logic [ADDR_BITS-1:0] c0_addr_of [TAGS];
    bit                   c1_pend    [TAGS];
    logic [ADDR_BITS-1:0] c1_addr_of [TAGS];
    int                   rd_pend_cnt [MEM_WORDS];
    int                   wr_pend_cnt [MEM_WORDS];
    logic [TAG_BITS-1:0]  c0_next_tag;
    logic [TAG_BITS-1:0]  c1_next_tag;

    int c0_out;
    int c1_out;
    int sent_total;
    int err_count;
    int test_err_start;
    int tests_failed;
    int cycle_count;

    // Almost full levels as seen at the last falling edge
    bit c0_af_seen;
    bit c1_af_seen;

    // Run of consecutive responses on one channel, used by the fairness test
    bit fair_on;
    bit streak_c1;
    int streak;

    mpf_lite_top u_mpf_lite_top (
        .clk            (clk),
        .rst            (rst),
        .c0_tx_valid    (c0_tx_valid),
        .c0_tx_addr     (c0_tx_addr),
        .c0_tx_tag      (c0_tx_tag),
        .c1_tx_valid    (c1_tx_valid),
        .c1_tx_addr     (c1_tx_addr),
        .c1_tx_tag      (c1_tx_tag),
        .c1_tx_data     (c1_tx_data),
        .c0_tx_alm_full (c0_tx_alm_full),
        .c1_tx_alm_full (c1_tx_alm_full),
        .c0_rx_valid    (c0_rx_valid),
        .c0_rx_tag      (c0_rx_tag),
        .c0_rx_data     (c0_rx_data),
        .c1_rx_valid    (c1_rx_valid),
        .c1_rx_tag      (c1_rx_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, actual, expected);
            err_count++;
        end
    endtask

    // A read response must match an outstanding read and the data captured when it was sent
    task automatic check_read_resp(input logic [TAG_BITS-1:0] tag,
                                   input logic [DATA_BITS-1:0] data);
        if (!c0_pend[tag])
        begin
            $display("Read response at %0t carries tag %0d with no read outstanding", $time, tag);
            err_count++;
        end
        else
        begin
            if (data !== c0_exp[tag])
            begin
                $display("[FAIL] %0t c0_rx_data for tag %0d: got %h, expected %h",
                         $time, tag, data, c0_exp[tag]);
                err_count++;
            end
            c0_pend[tag] = 1'b0;
            rd_pend_cnt[c0_addr_of[tag]]--;
            c0_out--;
        end
    endtask

    task automatic check_write_ack(input logic [TAG_BITS-1:0] tag);
        if (!c1_pend[tag])
        begin
            $display("Write ack at %0t carries tag %0d with no write outstanding", $time, tag);
            err_count++;
        end
        else
        begin
            c1_pend[tag] = 1'b0;
            wr_pend_cnt[c1_addr_of[tag]]--;
            c1_out--;
        end
    endtask

    // ========================================
    // Stimulus helpers
    // ========================================

    // Reads avoid words with a write in flight, writes avoid words with a read in flight
    function automatic logic [ADDR_BITS-1:0] pick_addr(input bit for_read);
        int                   start;
        logic [ADDR_BITS-1:0] cand;
        start = int'($urandom % MEM_WORDS);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            cand = ADDR_BITS'(start + i);
            if (for_read ? (wr_pend_cnt[cand] == 0) : (rd_pend_cnt[cand] == 0))
            begin
                return cand;
            end
        end
        return ADDR_BITS'(start);
    endfunction

    // Next tag on a channel that is not still waiting for its answer
    function automatic logic [TAG_BITS-1:0] free_tag(input bit write_ch);
        logic [TAG_BITS-1:0] t;
        t = write_ch ? c1_next_tag : c0_next_tag;
        while (write_ch ? c1_pend[t] : c0_pend[t])
        begin
            t = t + 1'b1;
        end
        if (write_ch)
        begin
            c1_next_tag = t + 1'b1;
        end
        else
        begin
            c0_next_tag = t + 1'b1;
        end
        return t;
    endfunction

    // Rising edge with both valids dropped unless a request is issued after it
    task automatic begin_cycle();
        @(posedge clk);
        c0_tx_valid <= 1'b0;
        c1_tx_valid <= 1'b0;
    endtask

    task automatic issue_read(input logic [ADDR_BITS-1:0] addr);
        logic [TAG_BITS-1:0] tag;
        tag = free_tag(1'b0);
        c0_pend[tag]    = 1'b1;
        c0_exp[tag]     = model_mem[addr];
        c0_addr_of[tag] = addr;
        rd_pend_cnt[addr]++;
        c0_out++;
        sent_total++;
        c0_tx_valid <= 1'b1;
        c0_tx_addr  <= addr;
        c0_tx_tag   <= tag;
    endtask

    task automatic issue_write(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data);
        logic [TAG_BITS-1:0] tag;
        tag = free_tag(1'b1);
        c1_pend[tag]    = 1'b1;
        c1_addr_of[tag] = addr;
        model_mem[addr] = data;
        wr_pend_cnt[addr]++;
        c1_out++;
        sent_total++;
        c1_tx_valid <= 1'b1;
        c1_tx_addr  <= addr;
        c1_tx_tag   <= tag;
        c1_tx_data  <= data;
    endtask

    task automatic wait_drain();
        while (c0_out != 0 || c1_out != 0)
        begin
            begin_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_start)
        begin
            $display("test %-14s done with no errors", name);
        end
        else
        begin
            $display("test %-14s done with %0d errors", name, err_count - test_err_start);
            tests_failed++;
        end
        test_err_start = err_count;
    endtask

    // ========================================
    // Response monitor and timeout
    // ========================================

    // Outputs are sampled mid cycle where the registered responses are settled
    always @(negedge clk)
    begin
        c0_af_seen = c0_tx_alm_full;
        c1_af_seen = c1_tx_alm_full;
        if (!rst && (c0_rx_valid || c1_rx_valid))
        begin
            if (c0_rx_valid)
            begin
                check_read_resp(c0_rx_tag, c0_rx_data);
            end
            if (c1_rx_valid)
            begin
                check_write_ack(c1_rx_tag);
            end
            if (fair_on)
            begin
                if (streak > 0 && streak_c1 == c1_rx_valid)
                begin
                    streak++;
                end
                else
                begin
                    streak    = 1;
                    streak_c1 = c1_rx_valid;
                end
                if (streak > 3 && (streak_c1 ? c0_out : c1_out) > 2)
                begin
                    $display("Channel %0d got %0d responses in a row at %0t, other waits",
                             streak_c1, streak, $time);
                    err_count++;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles with %0d reads and %0d writes unanswered",
                     cycle_count, c0_out, c1_out);
            $display("Some tests failed");
            $finish;
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        bit want_rd;
        bit want_wr;
        int rand_end;
        int flood_sent;
        int rd_sent;
        int wr_sent;

        void'($urandom(SEED));
        rst         = 1'b1;
        c0_tx_valid = 1'b0;
        c0_tx_addr  = '0;
        c0_tx_tag   = '0;
        c1_tx_valid = 1'b0;
        c1_tx_addr  = '0;
        c1_tx_tag   = '0;
        c1_tx_data  = '0;
        c0_next_tag = '0;
        c1_next_tag = '0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            model_mem[i] = '0;
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_bit("c0_rx_valid", c0_rx_valid, 1'b0);
        check_bit("c1_rx_valid", c1_rx_valid, 1'b0);
        check_bit("c0_tx_alm_full", c0_tx_alm_full, 1'b0);
        check_bit("c1_tx_alm_full", c1_tx_alm_full, 1'b0);
        finish_test("reset_state");

        // Word 0x2a is never written before its read, so the model expects zero
        begin_cycle();
        issue_write(6'h15, 32'hc0de_1234);
        wait_drain();
        begin_cycle();
        issue_read(6'h15);
        wait_drain();
        begin_cycle();
        issue_read(6'h2a);
        wait_drain();
        finish_test("write_readback");

        rand_end = sent_total + RANDOM_REQS;
        while (sent_total < rand_end)
        begin
            begin_cycle();
            want_rd = (($urandom & 1) == 1) && !c0_af_seen;
            want_wr = (($urandom & 1) == 1) && !c1_af_seen;
            if (want_rd && sent_total < rand_end)
            begin
                issue_read(pick_addr(1'b1));
            end
            if (want_wr && sent_total < rand_end)
            begin
                issue_write(pick_addr(1'b0), $urandom);
            end
        end
        wait_drain();
        finish_test("random_traffic");

        // Writes ignore almost full, reads keep the arbiter busy so the write FIFO fills
        flood_sent = 0;
        while (!c1_af_seen && flood_sent < FLOOD_MAX)
        begin
            begin_cycle();
            if (c1_out > FIFO_ENTRIES + MEM_LATENCY)
            begin
                $display("Almost full still low at %0t with %0d writes in flight", $time, c1_out);
                err_count++;
            end
            issue_write(pick_addr(1'b0), $urandom);
            if (!c0_af_seen)
            begin
                issue_read(pick_addr(1'b1));
            end
            flood_sent++;
        end
        if (!c1_af_seen)
        begin
            $display("Channel 1 almost full never rose during the write flood");
            err_count++;
        end
        wait_drain();
        finish_test("backpressure");

        fair_on = 1'b1;
        streak  = 0;
        rd_sent = 0;
        wr_sent = 0;
        while (rd_sent < FAIR_REQS || wr_sent < FAIR_REQS)
        begin
            begin_cycle();
            if (rd_sent < FAIR_REQS && !c0_af_seen)
            begin
                issue_read(pick_addr(1'b1));
                rd_sent++;
            end
            if (wr_sent < FAIR_REQS && !c1_af_seen)
            begin
                issue_write(pick_addr(1'b0), $urandom);
                wr_sent++;
            end
        end
        wait_drain();
        fair_on = 1'b0;
        finish_test("fairness");

        $display("5 tests run, %0d failed, %0d check errors", tests_failed, err_count);
        if (err_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: mpf_lite_top.f
source/mpf_lite_pkg.sv
source/req_fifo.sv
source/afu_req_buffer.sv
source/req_issue_arb.sv
source/local_mem_resp.sv
source/mpf_lite_top.sv
bench/tb_mpf_lite_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mpf_lite simulation with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mpf_lite_top \
    -f mpf_lite_top.f -o sim_mpf_lite > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_mpf_lite > sim.log 2>&1
cat sim.log

grep -q "^All tests passed$" sim.log && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

// File: source/afu_req_buffer.sv
// AFU side request buffering for both channels with an optional read bypass

`timescale 1ns/1ps

module afu_req_buffer
    import mpf_lite_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 c0_tx_valid,
    input  logic [ADDR_BITS-1:0] c0_tx_addr,
    input  logic [TAG_BITS-1:0]  c0_tx_tag,
    input  logic                 c1_tx_valid,
    input  logic [ADDR_BITS-1:0] c1_tx_addr,
    input  logic [TAG_BITS-1:0]  c1_tx_tag,
    input  logic [DATA_BITS-1:0] c1_tx_data,
    input  logic                 c0_deq,
    input  logic                 c1_deq,
    output logic                 c0_tx_alm_full,
    output logic                 c1_tx_alm_full,
    output logic                 c0_head_valid,
    output logic [ADDR_BITS-1:0] c0_head_addr,
    output logic [TAG_BITS-1:0]  c0_head_tag,
    output logic                 c1_head_valid,
    output logic [ADDR_BITS-1:0] c1_head_addr,
    output logic [TAG_BITS-1:0]  c1_head_tag,
    output logic [DATA_BITS-1:0] c1_head_data
);

    // ========================================
    // Channel 0 reads
    // ========================================

    logic [C0_REQ_BITS-1:0] c0_fifo_first;
    logic                   c0_fifo_not_empty;
    logic                   c0_fifo_enq;
    logic                   c0_fifo_deq;

    generate
        if (ENABLE_C0_BYPASS)
        begin : g_c0_bypass
            // An arriving read is offered directly when nothing is queued ahead of it
            assign c0_head_valid = c0_fifo_not_empty || c0_tx_valid;
            assign {c0_head_addr, c0_head_tag} =
                c0_fifo_not_empty ? c0_fifo_first : {c0_tx_addr, c0_tx_tag};

            // Only queue the read if it was not consumed in its arrival cycle
            assign c0_fifo_enq = c0_tx_valid && (c0_fifo_not_empty || !c0_deq);
            assign c0_fifo_deq = c0_deq && c0_fifo_not_empty;
        end
        else
        begin : g_c0_fifo_only
            // Every read is queued first
            assign c0_head_valid = c0_fifo_not_empty;
            assign {c0_head_addr, c0_head_tag} = c0_fifo_first;
            assign c0_fifo_enq = c0_tx_valid;
            assign c0_fifo_deq = c0_deq;
        end
    endgenerate

    req_fifo #(
        .N_DATA_BITS (C0_REQ_BITS)
    ) u_c0_fifo (
        .clk         (clk),
        .rst         (rst),
        .enq_data    ({c0_tx_addr, c0_tx_tag}),
        .enq_en      (c0_fifo_enq),
        .deq_en      (c0_fifo_deq),
        .first       (c0_fifo_first),
        .not_empty   (c0_fifo_not_empty),
        .almost_full (c0_tx_alm_full)
    );

    // ========================================
    // Channel 1 writes
    // ========================================

    // No bypass here, the mux on the data path is not worth it for writes
    logic [C1_REQ_BITS-1:0] c1_fifo_first;

    assign {c1_head_addr, c1_head_tag, c1_head_data} = c1_fifo_first;

    req_fifo #(
        .N_DATA_BITS (C1_REQ_BITS)
    ) u_c1_fifo (
        .clk         (clk),
        .rst         (rst),
        .enq_data    ({c1_tx_addr, c1_tx_tag, c1_tx_data}),
        .enq_en      (c1_tx_valid),
        .deq_en      (c1_deq),
        .first       (c1_fifo_first),
        .not_empty   (c1_head_valid),
        .almost_full (c1_tx_alm_full)
    );

    // A read head that the issue stage skips must still be offered next cycle,
    // including one that arrived through the bypass
    assert property (@(posedge clk) disable iff (rst)
        (c0_head_valid && !c0_deq) |=> c0_head_valid);

endmodule

// File: source/local_mem_resp.sv
// Local memory array and fixed latency response pipeline for reads and writes

`timescale 1ns/1ps

module local_mem_resp
    import mpf_lite_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  req_kind_t            issue_kind,
    input  logic [ADDR_BITS-1:0] issue_addr,
    input  logic [TAG_BITS-1:0]  issue_tag,
    input  logic [DATA_BITS-1:0] issue_data,
    output logic                 c0_rx_valid,
    output logic [TAG_BITS-1:0]  c0_rx_tag,
    output logic [DATA_BITS-1:0] c0_rx_data,
    output logic                 c1_rx_valid,
    output logic [TAG_BITS-1:0]  c1_rx_tag
);

    logic [DATA_BITS-1:0] mem [MEM_WORDS];

    // ========================================
    // Response pipeline, stage 0 is loaded at issue
    // ========================================

    req_kind_t            kind_q [MEM_LATENCY];
    logic [TAG_BITS-1:0]  tag_q  [MEM_LATENCY];
    logic [DATA_BITS-1:0] data_q [MEM_LATENCY];

    // The array is cleared on reset so unwritten words read as zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (issue_kind == REQ_WRITE)
        begin
            mem[issue_addr] <= issue_data;
        end
    end

    // Kinds decide which channel fires, so they are the only reset stages
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < MEM_LATENCY; i++)
            begin
                kind_q[i] <= REQ_NONE;
            end
        end
        else
        begin
            kind_q[0] <= issue_kind;
            for (int i = 1; i < MEM_LATENCY; i++)
            begin
                kind_q[i] <= kind_q[i-1];
            end
        end
    end

    // Read data is taken from the array before any later write lands
    always_ff @(posedge clk)
    begin
        tag_q[0]  <= issue_tag;
        data_q[0] <= mem[issue_addr];
        for (int i = 1; i < MEM_LATENCY; i++)
        begin
            tag_q[i]  <= tag_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    // Last stage steers onto the channel matching its kind
    assign c0_rx_valid = (kind_q[MEM_LATENCY-1] == REQ_READ);
    assign c0_rx_tag   = tag_q[MEM_LATENCY-1];
    assign c0_rx_data  = data_q[MEM_LATENCY-1];
    assign c1_rx_valid = (kind_q[MEM_LATENCY-1] == REQ_WRITE);
    assign c1_rx_tag   = tag_q[MEM_LATENCY-1];

endmodule

// File: source/mpf_lite_pkg.sv
// Widths, buffer depths, thresholds and the request kind enum for mpf_lite

package mpf_lite_pkg;

    // ========================================
    // Request field widths
    // ========================================

    // Word address into the local memory
    localparam int ADDR_BITS = 6;

    // Tag carried by each request and echoed in its response
    localparam int TAG_BITS = 8;

    // One memory word
    localparam int DATA_BITS = 32;

    // The address space is fully populated
    localparam int MEM_WORDS = 1 << ADDR_BITS;

    // Packed read request is address above tag
    localparam int C0_REQ_BITS = ADDR_BITS + TAG_BITS;

    // Packed write request is address, then tag, then data in the low bits
    localparam int C1_REQ_BITS = ADDR_BITS + TAG_BITS + DATA_BITS;

    // ========================================
    // Request buffering
    // ========================================

    // Depth of each channel FIFO
    localparam int FIFO_ENTRIES = 8;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_ENTRIES);

    // The count must also represent a completely full FIFO
    localparam int FIFO_CNT_BITS = $clog2(FIFO_ENTRIES + 1);

    // Almost full rises once this many slots or fewer remain free
    localparam int ALM_FULL_THRESHOLD = 4;

    // Occupancy at which almost full is raised
    localparam int FIFO_ALM_FULL_COUNT = FIFO_ENTRIES - ALM_FULL_THRESHOLD;

    // Reads may skip the channel 0 FIFO when it is empty
    localparam bit ENABLE_C0_BYPASS = 1'b1;

    // ========================================
    // Responder
    // ========================================

    // Edges from a registered issue to its response strobe
    localparam int MEM_LATENCY = 2;

    // What the issue stage hands the responder in a given cycle
    typedef enum logic [1:0]
    {
        REQ_NONE  = 2'd0,
        REQ_READ  = 2'd1,
        REQ_WRITE = 2'd2
    } req_kind_t;

endpackage

// File: source/mpf_lite_top.sv
// Top level chaining request buffer, issue stage and local memory responder

`timescale 1ns/1ps

module mpf_lite_top
    import mpf_lite_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 c0_tx_valid,
    input  logic [ADDR_BITS-1:0] c0_tx_addr,
    input  logic [TAG_BITS-1:0]  c0_tx_tag,
    input  logic                 c1_tx_valid,
    input  logic [ADDR_BITS-1:0] c1_tx_addr,
    input  logic [TAG_BITS-1:0]  c1_tx_tag,
    input  logic [DATA_BITS-1:0] c1_tx_data,
    output logic                 c0_tx_alm_full,
    output logic                 c1_tx_alm_full,
    output logic                 c0_rx_valid,
    output logic [TAG_BITS-1:0]  c0_rx_tag,
    output logic [DATA_BITS-1:0] c0_rx_data,
    output logic                 c1_rx_valid,
    output logic [TAG_BITS-1:0]  c1_rx_tag
);

    // Buffered heads toward the issue stage
    logic                 c0_head_valid;
    logic [ADDR_BITS-1:0] c0_head_addr;
    logic [TAG_BITS-1:0]  c0_head_tag;
    logic                 c1_head_valid;
    logic [ADDR_BITS-1:0] c1_head_addr;
    logic [TAG_BITS-1:0]  c1_head_tag;
    logic [DATA_BITS-1:0] c1_head_data;
    logic                 c0_deq;
    logic                 c1_deq;

    // Registered issue toward the responder
    req_kind_t            issue_kind;
    logic [ADDR_BITS-1:0] issue_addr;
    logic [TAG_BITS-1:0]  issue_tag;
    logic [DATA_BITS-1:0] issue_data;

    afu_req_buffer u_afu_req_buffer (
        .clk            (clk),
        .rst            (rst),
        .c0_tx_valid    (c0_tx_valid),
        .c0_tx_addr     (c0_tx_addr),
        .c0_tx_tag      (c0_tx_tag),
        .c1_tx_valid    (c1_tx_valid),
        .c1_tx_addr     (c1_tx_addr),
        .c1_tx_tag      (c1_tx_tag),
        .c1_tx_data     (c1_tx_data),
        .c0_deq         (c0_deq),
        .c1_deq         (c1_deq),
        .c0_tx_alm_full (c0_tx_alm_full),
        .c1_tx_alm_full (c1_tx_alm_full),
        .c0_head_valid  (c0_head_valid),
        .c0_head_addr   (c0_head_addr),
        .c0_head_tag    (c0_head_tag),
        .c1_head_valid  (c1_head_valid),
        .c1_head_addr   (c1_head_addr),
        .c1_head_tag    (c1_head_tag),
        .c1_head_data   (c1_head_data)
    );

    req_issue_arb u_req_issue_arb (
        .clk           (clk),
        .rst           (rst),
        .c0_head_valid (c0_head_valid),
        .c0_head_addr  (c0_head_addr),
        .c0_head_tag   (c0_head_tag),
        .c1_head_valid (c1_head_valid),
        .c1_head_addr  (c1_head_addr),
        .c1_head_tag   (c1_head_tag),
        .c1_head_data  (c1_head_data),
        .c0_deq        (c0_deq),
        .c1_deq        (c1_deq),
        .issue_kind    (issue_kind),
        .issue_addr    (issue_addr),
        .issue_tag     (issue_tag),
        .issue_data    (issue_data)
    );

    local_mem_resp u_local_mem_resp (
        .clk         (clk),
        .rst         (rst),
        .issue_kind  (issue_kind),
        .issue_addr  (issue_addr),
        .issue_tag   (issue_tag),
        .issue_data  (issue_data),
        .c0_rx_valid (c0_rx_valid),
        .c0_rx_tag   (c0_rx_tag),
        .c0_rx_data  (c0_rx_data),
        .c1_rx_valid (c1_rx_valid),
        .c1_rx_tag   (c1_rx_tag)
    );

endmodule

// File: source/req_fifo.sv
// Circular request FIFO with first word output, not empty and almost full flags

`timescale 1ns/1ps

module req_fifo
    import mpf_lite_pkg::*;
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    input  logic                   deq_en,
    output logic [N_DATA_BITS-1:0] first,
    output logic                   not_empty,
    output logic                   almost_full
);

    // Storage is a plain array so it maps onto LUT RAM
    logic [N_DATA_BITS-1:0] mem [FIFO_ENTRIES];

    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic [FIFO_CNT_BITS-1:0] count;

    // Write side of the storage
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap at the last entry, depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == FIFO_PTR_BITS'(FIFO_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == FIFO_PTR_BITS'(FIFO_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({enq_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head is visible whenever the FIFO holds anything
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Threshold slack absorbs the requests already in flight from the AFU
    assign almost_full = (count >= FIFO_CNT_BITS'(FIFO_ALM_FULL_COUNT));

    // The producer must have honoured almost full in time
    assert property (@(posedge clk) disable iff (rst)
        enq_en |-> (count < FIFO_CNT_BITS'(FIFO_ENTRIES)) || deq_en);

    // The consumer may only pop a head it has seen as valid
    assert property (@(posedge clk) disable iff (rst) deq_en |-> not_empty);

endmodule

// File: source/req_issue_arb.sv
// Round robin issue stage that pops one buffered head per cycle

`timescale 1ns/1ps

module req_issue_arb
    import mpf_lite_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 c0_head_valid,
    input  logic [ADDR_BITS-1:0] c0_head_addr,
    input  logic [TAG_BITS-1:0]  c0_head_tag,
    input  logic                 c1_head_valid,
    input  logic [ADDR_BITS-1:0] c1_head_addr,
    input  logic [TAG_BITS-1:0]  c1_head_tag,
    input  logic [DATA_BITS-1:0] c1_head_data,
    output logic                 c0_deq,
    output logic                 c1_deq,
    output req_kind_t            issue_kind,
    output logic [ADDR_BITS-1:0] issue_addr,
    output logic [TAG_BITS-1:0]  issue_tag,
    output logic [DATA_BITS-1:0] issue_data
);

    // Set when channel 1 was the most recent winner
    logic last_c1;

    // Reads win when alone or when writes went last
    assign c0_deq = c0_head_valid && (!c1_head_valid || last_c1);

    // Writes win when alone or when reads went last
    assign c1_deq = c1_head_valid && (!c0_head_valid || !last_c1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_c1    <= 1'b1;
            issue_kind <= REQ_NONE;
        end
        else
        begin
            if (c0_deq)
            begin
                last_c1    <= 1'b0;
                issue_kind <= REQ_READ;
            end
            else if (c1_deq)
            begin
                last_c1    <= 1'b1;
                issue_kind <= REQ_WRITE;
            end
            else
            begin
                issue_kind <= REQ_NONE;
            end
        end
    end

    // Payload follows the winner, write data is only loaded for writes
    always_ff @(posedge clk)
    begin
        if (c0_deq)
        begin
            issue_addr <= c0_head_addr;
            issue_tag  <= c0_head_tag;
        end
        else if (c1_deq)
        begin
            issue_addr <= c1_head_addr;
            issue_tag  <= c1_head_tag;
            issue_data <= c1_head_data;
        end
    end

    // One request per cycle into the responder
    assert property (@(posedge clk) disable iff (rst) !(c0_deq && c1_deq));

    // A write passed over for a read is served on the very next cycle
    assert property (@(posedge clk) disable iff (rst) (c0_deq && c1_head_valid) |=> c1_deq);

endmodule
